//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // --------------------
    // major opcodes
    // --------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // integer ops, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000; // also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL / SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // store widths
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB, SRA, SRAI

    // --------------------
    // instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // one word, several views
    typedef union packed {
        rv_r_fmt_t r_fmt;
        rv_i_fmt_t i_fmt;
        rv_s_fmt_t s_fmt;
        rv_b_fmt_t b_fmt;
        rv_j_fmt_t j_fmt;
    } rv_inst_t;

endpackage

`default_nettype wire

//--- source/ex_bus_pkg.sv
`default_nettype none

package ex_bus_pkg;

    // --------------------
    // datapath widths
    // --------------------
    localparam int SHAMT_W = 5; // shift amount bits

    typedef logic [31:0] xlen_t;    // register / data word
    typedef logic [31:0] addr_t;    // instruction or data address
    typedef logic [4:0]  reg_idx_t; // x0..x31

    // one write strobe per byte lane
    typedef logic [3:0] mem_strb_t;

endpackage

`default_nettype wire

//--- source/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import rv_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  wire xlen_t    op1_i,
    input  wire xlen_t    op2_i,
    input  wire rv_inst_t inst_i,
    output xlen_t         rd_data_o,
    output xlen_t         sum_o,
    output logic          eq_o,
    output logic          lt_s_o,
    output logic          lt_u_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [SHAMT_W-1:0] shamt;
    logic               is_sub;
    logic               is_sra;

    xlen_t       sum;
    logic [32:0] diff_ext; // bit 32 is the borrow
    xlen_t       diff;
    xlen_t       sll_res;
    xlen_t       srl_res;
    xlen_t       sr_mask;
    xlen_t       sra_res;

    assign opcode = inst_i.r_fmt.opcode;
    assign funct3 = inst_i.r_fmt.funct3;
    assign shamt  = op2_i[SHAMT_W-1:0];

    // funct7 and imm[11:5] share bits 31:25
    assign is_sub = (opcode == OPC_OP) && (inst_i.r_fmt.funct7 == F7_ALT);
    assign is_sra = (inst_i.i_fmt.imm[11:5] == F7_ALT);

    // --------------------
    // adder and subtractor
    // --------------------
    assign sum      = op1_i + op2_i;
    assign diff_ext = {1'b0, op1_i} - {1'b0, op2_i};
    assign diff     = diff_ext[31:0];

    // compare from the subtractor
    assign eq_o   = (op1_i == op2_i);
    assign lt_u_o = diff_ext[32];
    assign lt_s_o = (op1_i[31] ^ op2_i[31]) ? op1_i[31] : diff[31];

    // --------------------
    // shifter
    // --------------------
    assign sll_res = op1_i << shamt;
    assign srl_res = op1_i >> shamt;
    assign sr_mask = 32'hffff_ffff >> shamt;
    assign sra_res = srl_res | ({32{op1_i[31]}} & ~sr_mask); // sign fill

    assign sum_o = sum;

    // result select
    always_comb begin
        rd_data_o = '0;
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                case (funct3)
                    F3_ADD:  rd_data_o = is_sub ? diff : sum;
                    F3_SLL:  rd_data_o = sll_res;
                    F3_SLT:  rd_data_o = {31'b0, lt_s_o};
                    F3_SLTU: rd_data_o = {31'b0, lt_u_o};
                    F3_XOR:  rd_data_o = op1_i ^ op2_i;
                    F3_SR:   rd_data_o = is_sra ? sra_res : srl_res;
                    F3_OR:   rd_data_o = op1_i | op2_i;
                    F3_AND:  rd_data_o = op1_i & op2_i;
                    default: rd_data_o = '0;
                endcase
            end
            // operands already prepared by decode (pc+4, 0+imm, pc+imm)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: rd_data_o = sum;
            default: rd_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
    import rv_isa_pkg::*;
    import ex_bus_pkg::*;
#(
    parameter addr_t RESET_ADDR = 32'h0
) (
    input  wire rv_inst_t inst_i,
    input  wire addr_t    instaddr_i,
    input  wire addr_t    rs1_data_i,
    input  wire logic     eq_i,
    input  wire logic     lt_s_i,
    input  wire logic     lt_u_i,
    output logic          jump_en_o,
    output addr_t         jump_base_o,
    output addr_t         jump_ofst_o
);

    addr_t imm_i;
    addr_t imm_b;
    addr_t imm_j;

    // --------------------
    // immediates
    // --------------------
    assign imm_i = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign imm_b = {{20{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_11,
                    inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{12{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_19_12,
                    inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        jump_en_o   = 1'b0;
        jump_base_o = RESET_ADDR; // idle value
        jump_ofst_o = '0;
        case (inst_i.j_fmt.opcode)
            OPC_JAL: begin
                jump_en_o   = 1'b1;
                jump_base_o = instaddr_i;
                jump_ofst_o = imm_j;
            end
            OPC_JALR: begin
                jump_en_o   = 1'b1;
                jump_base_o = rs1_data_i;
                jump_ofst_o = imm_i;
            end
            OPC_BRANCH: begin
                jump_base_o = instaddr_i;
                jump_ofst_o = imm_b;
                case (inst_i.b_fmt.funct3)
                    F3_BEQ:  jump_en_o = eq_i;
                    F3_BNE:  jump_en_o = ~eq_i;
                    F3_BLT:  jump_en_o = lt_s_i;
                    F3_BGE:  jump_en_o = ~lt_s_i;
                    F3_BLTU: jump_en_o = lt_u_i;
                    F3_BGEU: jump_en_o = ~lt_u_i;
                    default: begin
                        // reserved funct3, back to idle
                        jump_base_o = RESET_ADDR;
                        jump_ofst_o = '0;
                    end
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/ex_lsu_req.sv
`timescale 1ns/1ps
`default_nettype none

module ex_lsu_req
    import rv_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  wire rv_inst_t inst_i,
    input  wire addr_t    sum_i,
    input  wire xlen_t    rs2_data_i,
    output logic          cs_o,
    output logic          mem_we_o,
    output mem_strb_t     mem_wem_o,
    output xlen_t         mem_din_o,
    output addr_t         mem_addr_o
);

    logic [1:0] lane;
    xlen_t      byte_word;
    xlen_t      half_lo;
    xlen_t      half_hi;

    assign lane = sum_i[1:0];

    // --------------------
    // lane placement
    // --------------------
    assign byte_word = {24'h0, rs2_data_i[7:0]} << {lane, 3'b000};
    assign half_lo   = {16'h0, rs2_data_i[15:0]};
    assign half_hi   = {rs2_data_i[15:0], 16'h0};

    always_comb begin
        cs_o       = 1'b0;
        mem_we_o   = 1'b0;
        mem_wem_o  = '0;
        mem_din_o  = '0;
        mem_addr_o = '0;
        case (inst_i.s_fmt.opcode)
            OPC_LOAD: begin
                cs_o       = 1'b1;
                mem_addr_o = sum_i; // read, no strobes
            end
            OPC_STORE: begin
                cs_o       = 1'b1;
                mem_we_o   = 1'b1;
                mem_addr_o = sum_i;
                case (inst_i.s_fmt.funct3)
                    F3_SB: begin
                        mem_din_o = byte_word;
                        mem_wem_o = mem_strb_t'(4'b0001 << lane);
                    end
                    F3_SH: begin
                        if (lane == 2'b00) begin
                            mem_din_o = half_lo;
                            mem_wem_o = 4'b0011;
                        end else begin
                            mem_din_o = half_hi; // any other offset uses upper half
                            mem_wem_o = 4'b1100;
                        end
                    end
                    F3_SW: begin
                        mem_din_o = rs2_data_i;
                        mem_wem_o = 4'b1111;
                    end
                    default: ; // reserved width writes nothing
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/ex_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg
    import rv_isa_pkg::*;
    import ex_bus_pkg::*;
#(
    parameter addr_t RESET_ADDR = 32'h0
) (
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    // next-state values
    input  wire rv_inst_t  inst_d_i,
    input  wire addr_t     instaddr_d_i,
    input  wire logic      regs_wen_d_i,
    input  wire reg_idx_t  rd_addr_d_i,
    input  wire xlen_t     rd_data_d_i,
    input  wire logic      cs_d_i,
    input  wire logic      mem_we_d_i,
    input  wire mem_strb_t mem_wem_d_i,
    input  wire xlen_t     mem_din_d_i,
    input  wire addr_t     mem_addr_d_i,
    input  wire logic      jump_en_d_i,
    input  wire addr_t     jump_base_d_i,
    input  wire addr_t     jump_ofst_d_i,
    // toward the memory stage
    output rv_inst_t       inst_o,
    output addr_t          instaddr_o,
    output logic           regs_wen_o,
    output reg_idx_t       rd_addr_o,
    output xlen_t          rd_data_o,
    output logic           cs_o,
    output logic           mem_we_o,
    output mem_strb_t      mem_wem_o,
    output xlen_t          mem_din_o,
    output addr_t          mem_addr_o,
    output logic           jump_en_o,
    output addr_t          jump_base_o,
    output addr_t          jump_ofst_o
);

    // --------------------
    // ex/mem boundary
    // --------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_o      <= '0;
            instaddr_o  <= '0;
            regs_wen_o  <= 1'b0;
            rd_addr_o   <= '0;
            rd_data_o   <= '0;
            cs_o        <= 1'b0;
            mem_we_o    <= 1'b0;
            mem_wem_o   <= '0;
            mem_din_o   <= '0;
            mem_addr_o  <= '0;
            jump_en_o   <= 1'b0;
            jump_base_o <= RESET_ADDR; // fetch restarts here
            jump_ofst_o <= '0;
        end else begin
            inst_o      <= inst_d_i;
            instaddr_o  <= instaddr_d_i;
            regs_wen_o  <= regs_wen_d_i;
            rd_addr_o   <= rd_addr_d_i;
            rd_data_o   <= rd_data_d_i;
            cs_o        <= cs_d_i;
            mem_we_o    <= mem_we_d_i;
            mem_wem_o   <= mem_wem_d_i;
            mem_din_o   <= mem_din_d_i;
            mem_addr_o  <= mem_addr_d_i;
            jump_en_o   <= jump_en_d_i;
            jump_base_o <= jump_base_d_i;
            jump_ofst_o <= jump_ofst_d_i;
        end
    end

endmodule

`default_nettype wire

//--- source/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top
    import rv_isa_pkg::*;
    import ex_bus_pkg::*;
#(
    parameter addr_t RESET_ADDR = 32'h0
) (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    // from id/ex
    input  wire rv_inst_t inst_i,
    input  wire addr_t    instaddr_i,
    input  wire xlen_t    rs1_data_i,
    input  wire xlen_t    rs2_data_i,
    input  wire xlen_t    op1_i,
    input  wire xlen_t    op2_i,
    input  wire logic     regs_wen_i,
    input  wire reg_idx_t rd_addr_i,
    // to ex/mem
    output rv_inst_t      inst_o,
    output addr_t         instaddr_o,
    output logic          regs_wen_o,
    output reg_idx_t      rd_addr_o,
    output xlen_t         rd_data_o,
    output logic          cs_o,
    output logic          mem_we_o,
    output mem_strb_t     mem_wem_o,
    output xlen_t         mem_din_o,
    output addr_t         mem_addr_o,
    output logic          jump_en_o,
    output addr_t         jump_base_o,
    output addr_t         jump_ofst_o
);

    // alu results
    xlen_t alu_rd_data;
    xlen_t alu_sum;
    logic  alu_eq;
    logic  alu_lt_s;
    logic  alu_lt_u;

    // branch request
    logic  br_jump_en;
    addr_t br_jump_base;
    addr_t br_jump_ofst;

    // memory request
    logic      lsu_cs;
    logic      lsu_we;
    mem_strb_t lsu_wem;
    xlen_t     lsu_din;
    addr_t     lsu_addr;

    // --------------------
    // combinational units
    // --------------------
    ex_alu u_alu (
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .inst_i    (inst_i),
        .rd_data_o (alu_rd_data),
        .sum_o     (alu_sum),
        .eq_o      (alu_eq),
        .lt_s_o    (alu_lt_s),
        .lt_u_o    (alu_lt_u)
    );

    ex_branch_unit #(
        .RESET_ADDR (RESET_ADDR)
    ) u_branch (
        .inst_i      (inst_i),
        .instaddr_i  (instaddr_i),
        .rs1_data_i  (rs1_data_i),
        .eq_i        (alu_eq),
        .lt_s_i      (alu_lt_s),
        .lt_u_i      (alu_lt_u),
        .jump_en_o   (br_jump_en),
        .jump_base_o (br_jump_base),
        .jump_ofst_o (br_jump_ofst)
    );

    ex_lsu_req u_lsu_req (
        .inst_i     (inst_i),
        .sum_i      (alu_sum), // effective address
        .rs2_data_i (rs2_data_i),
        .cs_o       (lsu_cs),
        .mem_we_o   (lsu_we),
        .mem_wem_o  (lsu_wem),
        .mem_din_o  (lsu_din),
        .mem_addr_o (lsu_addr)
    );

    // --------------------
    // output register
    // --------------------
    ex_stage_reg #(
        .RESET_ADDR (RESET_ADDR)
    ) u_stage_reg (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_d_i      (inst_i),
        .instaddr_d_i  (instaddr_i),
        .regs_wen_d_i  (regs_wen_i),
        .rd_addr_d_i   (rd_addr_i),
        .rd_data_d_i   (alu_rd_data),
        .cs_d_i        (lsu_cs),
        .mem_we_d_i    (lsu_we),
        .mem_wem_d_i   (lsu_wem),
        .mem_din_d_i   (lsu_din),
        .mem_addr_d_i  (lsu_addr),
        .jump_en_d_i   (br_jump_en),
        .jump_base_d_i (br_jump_base),
        .jump_ofst_d_i (br_jump_ofst),
        .inst_o        (inst_o),
        .instaddr_o    (instaddr_o),
        .regs_wen_o    (regs_wen_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o),
        .cs_o          (cs_o),
        .mem_we_o      (mem_we_o),
        .mem_wem_o     (mem_wem_o),
        .mem_din_o     (mem_din_o),
        .mem_addr_o    (mem_addr_o),
        .jump_en_o     (jump_en_o),
        .jump_base_o   (jump_base_o),
        .jump_ofst_o   (jump_ofst_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top
    import rv_isa_pkg::*;
    import ex_bus_pkg::*;
;

    localparam addr_t RESET_ADDR = 32'h0000_0080;

    localparam int N_INT    = 200;
    localparam int N_SHIFT  = 60;
    localparam int N_CTRL   = 80;
    localparam int N_MEM    = 40;
    localparam int N_STREAM = 100;
    localparam int N_VEC    = N_INT + N_SHIFT + N_CTRL + N_MEM + N_STREAM;
    localparam int TIMEOUT_CYC = 5 + N_VEC + 20;

    typedef struct packed {
        rv_inst_t inst;
        addr_t    instaddr;
        xlen_t    rs1;
        xlen_t    rs2;
        xlen_t    op1;
        xlen_t    op2;
        logic     wen;
        reg_idx_t rd;
    } in_set_t;

    typedef struct packed {
        rv_inst_t  inst;
        addr_t     instaddr;
        logic      wen;
        reg_idx_t  rd;
        xlen_t     rd_data;
        logic      cs;
        logic      we;
        mem_strb_t wem;
        xlen_t     din;
        addr_t     maddr;
        logic      jen;
        addr_t     jbase;
        addr_t     jofst;
    } out_set_t;

    logic     clk = 1'b0;
    logic     rst_n_i;
    rv_inst_t inst_i;
    addr_t    instaddr_i;
    xlen_t    rs1_data_i;
    xlen_t    rs2_data_i;
    xlen_t    op1_i;
    xlen_t    op2_i;
    logic     regs_wen_i;
    reg_idx_t rd_addr_i;

    rv_inst_t  inst_o;
    addr_t     instaddr_o;
    logic      regs_wen_o;
    reg_idx_t  rd_addr_o;
    xlen_t     rd_data_o;
    logic      cs_o;
    logic      mem_we_o;
    mem_strb_t mem_wem_o;
    xlen_t     mem_din_o;
    addr_t     mem_addr_o;
    logic      jump_en_o;
    addr_t     jump_base_o;
    addr_t     jump_ofst_o;

    logic [31:0] lfsr = 32'hab60;
    logic        vld;     // inputs this cycle are a vector to check
    logic        vec_bad;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cyc_cnt = 0;
    out_set_t    exp_q[$];

    ex_top #(
        .RESET_ADDR (RESET_ADDR)
    ) uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .instaddr_i  (instaddr_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .regs_wen_i  (regs_wen_i),
        .rd_addr_i   (rd_addr_i),
        .inst_o      (inst_o),
        .instaddr_o  (instaddr_o),
        .regs_wen_o  (regs_wen_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .cs_o        (cs_o),
        .mem_we_o    (mem_we_o),
        .mem_wem_o   (mem_wem_o),
        .mem_din_o   (mem_din_o),
        .mem_addr_o  (mem_addr_o),
        .jump_en_o   (jump_en_o),
        .jump_base_o (jump_base_o),
        .jump_ofst_o (jump_ofst_o)
    );

    always #10 clk = ~clk;

    // --------------------
    // random source
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic out_set_t ex_ref(input in_set_t s);
        out_set_t   r;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       alt;
        logic [4:0] sh;
        xlen_t      sum;
        logic [1:0] ofs;
        opc = s.inst[6:0];
        f3  = s.inst[14:12];
        alt = (s.inst[31:25] == F7_ALT); // funct7 or imm[11:5]
        sh  = s.op2[4:0];
        sum = s.op1 + s.op2;
        ofs = sum[1:0];
        r          = '0;
        r.inst     = s.inst;
        r.instaddr = s.instaddr;
        r.wen      = s.wen;
        r.rd       = s.rd;
        r.jbase    = RESET_ADDR;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                case (f3)
                    F3_ADD:  r.rd_data = (opc == OPC_OP && alt) ? s.op1 - s.op2 : sum;
                    F3_SLL:  r.rd_data = s.op1 << sh;
                    F3_SLT:  r.rd_data = ($signed(s.op1) < $signed(s.op2)) ? 32'd1 : 32'd0;
                    F3_SLTU: r.rd_data = (s.op1 < s.op2) ? 32'd1 : 32'd0;
                    F3_XOR:  r.rd_data = s.op1 ^ s.op2;
                    F3_SR:   r.rd_data = alt ? xlen_t'($signed(s.op1) >>> sh) : s.op1 >> sh;
                    F3_OR:   r.rd_data = s.op1 | s.op2;
                    default: r.rd_data = s.op1 & s.op2;
                endcase
            end
            OPC_LUI, OPC_AUIPC: r.rd_data = sum;
            OPC_JAL: begin
                r.rd_data = sum;
                r.jen     = 1'b1;
                r.jbase   = s.instaddr;
                r.jofst   = {{12{s.inst[31]}}, s.inst[19:12], s.inst[20], s.inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                r.rd_data = sum;
                r.jen     = 1'b1;
                r.jbase   = s.rs1;
                r.jofst   = {{20{s.inst[31]}}, s.inst[31:20]};
            end
            OPC_BRANCH: begin
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    r.jbase = s.instaddr;
                    r.jofst = {{20{s.inst[31]}}, s.inst[7], s.inst[30:25], s.inst[11:8], 1'b0};
                end
                case (f3)
                    F3_BEQ:  r.jen = (s.op1 == s.op2);
                    F3_BNE:  r.jen = (s.op1 != s.op2);
                    F3_BLT:  r.jen = ($signed(s.op1) < $signed(s.op2));
                    F3_BGE:  r.jen = ($signed(s.op1) >= $signed(s.op2));
                    F3_BLTU: r.jen = (s.op1 < s.op2);
                    F3_BGEU: r.jen = (s.op1 >= s.op2);
                    default: r.jen = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                r.cs    = 1'b1;
                r.maddr = sum;
            end
            OPC_STORE: begin
                r.cs    = 1'b1;
                r.we    = 1'b1;
                r.maddr = sum;
                if (f3 == F3_SB) begin
                    r.wem[ofs]          = 1'b1;
                    r.din[8*ofs +: 8]   = s.rs2[7:0];
                end else if (f3 == F3_SH && ofs == 2'd0) begin
                    r.wem       = 4'b0011;
                    r.din[15:0] = s.rs2[15:0];
                end else if (f3 == F3_SH) begin
                    r.wem        = 4'b1100; // odd offsets land high too
                    r.din[31:16] = s.rs2[15:0];
                end else if (f3 == F3_SW) begin
                    r.wem = 4'b1111;
                    r.din = s.rs2;
                end
            end
            default: ; // unknown opcode, all idle
        endcase
        return r;
    endfunction

    // --------------------
    // stimulus
    // --------------------
    function automatic logic [2:0] br_f3(input int k);
        case (k)
            0:       return F3_BEQ;
            1:       return F3_BNE;
            2:       return F3_BLT;
            3:       return F3_BGE;
            4:       return F3_BLTU;
            default: return F3_BGEU;
        endcase
    endfunction

    // cat: 0 int, 1 shift, 2 branch, 3 jal, 4 jalr, 5 store, 6 load, 7 lui, 8 auipc, 9 unknown
    function automatic in_set_t make_vec(input int cat, input int sel);
        in_set_t     v;
        logic [31:0] w;
        logic [1:0]  ofs;
        w          = rand_bits(32);
        v.instaddr = rand_bits(30) << 2;
        v.rs1      = rand_bits(32);
        v.rs2      = rand_bits(32);
        v.op1      = v.rs1;
        v.op2      = v.rs2;
        v.wen      = 1'b1;
        v.rd       = w[11:7];
        case (cat)
            0, 1: begin
                if (cat == 1) begin
                    w[14:12]  = rand_bits(1) ? F3_SR : F3_SLL;
                    v.op1[31] = (rand_bits(2) != 0); // mostly negative
                end
                w[6:0] = rand_bits(1) ? OPC_OP : OPC_OP_IMM;
                if (w[6:0] == OPC_OP || w[14:12] == F3_SLL || w[14:12] == F3_SR)
                    w[31:25] = rand_bits(1) ? F7_ALT : 7'h00;
                if (w[6:0] == OPC_OP_IMM)
                    v.op2 = {{20{w[31]}}, w[31:20]};
            end
            2: begin
                w[6:0]   = OPC_BRANCH;
                w[14:12] = br_f3(sel);
                v.wen    = 1'b0;
                case (rand_bits(2))
                    0:       v.rs2 = v.rs1;
                    1:       v.rs2 = v.rs1 ^ 32'h8000_0000; // sign bit only
                    default: ;
                endcase
                v.op1 = v.rs1;
                v.op2 = v.rs2;
            end
            3, 4: begin
                w[6:0] = (cat == 3) ? OPC_JAL : OPC_JALR;
                if (cat == 4)
                    w[14:12] = 3'b000;
                v.op1 = v.instaddr; // link value pc+4
                v.op2 = 32'd4;
            end
            5, 6: begin
                w[6:0] = (cat == 5) ? OPC_STORE : OPC_LOAD;
                ofs    = rand_bits(2);
                if (cat == 5) begin
                    w[14:12] = (sel < 4) ? F3_SB : (sel < 6) ? F3_SH : F3_SW;
                    if (sel < 4)
                        ofs = sel[1:0];
                    else if (sel < 6)
                        ofs = (sel == 4) ? 2'd0 : 2'd2;
                    w[8:7] = ofs;
                    v.wen  = 1'b0;
                    v.op2  = {{20{w[31]}}, w[31:25], w[11:7]};
                end else begin
                    w[21:20] = ofs;
                    v.op2    = {{20{w[31]}}, w[31:20]};
                end
                v.op1 = rand_bits(30) << 2; // aligned base
            end
            7, 8: begin
                w[6:0] = (cat == 7) ? OPC_LUI : OPC_AUIPC;
                v.op1  = (cat == 7) ? 32'h0 : v.instaddr;
                v.op2  = {w[31:12], 12'h000};
            end
            default: w[6:0] = 7'b0001011; // custom-0, not decoded here
        endcase
        v.inst = w;
        return v;
    endfunction

    task automatic apply_vec(input in_set_t v);
        @(posedge clk);
        inst_i     <= v.inst;
        instaddr_i <= v.instaddr;
        rs1_data_i <= v.rs1;
        rs2_data_i <= v.rs2;
        op1_i      <= v.op1;
        op2_i      <= v.op2;
        regs_wen_i <= v.wen;
        rd_addr_i  <= v.rd;
        vld        <= 1'b1;
    endtask

    task automatic run_test(input string name, input int mode, input int n);
        in_set_t v;
        int      i;
        int      cat;
        int      sel;
        int      err0;
        int      chk0;
        err0 = n_fail;
        chk0 = n_pass + n_fail;
        for (i = 0; i < n; i++) begin
            sel = i % 8;
            case (mode)
                0:       cat = 0;
                1:       cat = 1;
                2:       cat = (sel < 6) ? 2 : sel - 3;
                3:       cat = (sel < 7) ? 5 : 6;
                default: cat = (i == n / 2) ? 9 : int'(rand_bits(4)) % 10;
            endcase
            v = make_vec(cat, sel);
            apply_vec(v);
        end
        @(posedge clk);
        vld <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        $display("%-10s %0d checks, %0d errors", name, n_pass + n_fail - chk0, n_fail - err0);
    endtask

    // --------------------
    // checks
    // --------------------
    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            vec_bad = 1'b1;
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            vec_bad = 1'b1;
        end
    endtask

    task automatic check_strb(input string what, input mem_strb_t got, input mem_strb_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            vec_bad = 1'b1;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            vec_bad = 1'b1;
        end
    endtask

    task automatic check_idle(input string when);
        vec_bad = 1'b0;
        check_bit({when, " regs_wen_o"}, regs_wen_o, 1'b0);
        check_bit({when, " cs_o"}, cs_o, 1'b0);
        check_bit({when, " mem_we_o"}, mem_we_o, 1'b0);
        check_strb({when, " mem_wem_o"}, mem_wem_o, 4'b0000);
        check_bit({when, " jump_en_o"}, jump_en_o, 1'b0);
        check_addr({when, " jump_base_o"}, jump_base_o, RESET_ADDR);
        if (vec_bad)
            n_fail++;
        else
            n_pass++;
    endtask

    task automatic compare_out(input out_set_t e);
        vec_bad = 1'b0;
        check_word("inst_o", xlen_t'(inst_o), xlen_t'(e.inst));
        check_addr("instaddr_o", instaddr_o, e.instaddr);
        check_bit("regs_wen_o", regs_wen_o, e.wen);
        check_word("rd_addr_o", xlen_t'(rd_addr_o), xlen_t'(e.rd));
        check_word("rd_data_o", rd_data_o, e.rd_data);
        check_bit("cs_o", cs_o, e.cs);
        check_bit("mem_we_o", mem_we_o, e.we);
        check_strb("mem_wem_o", mem_wem_o, e.wem);
        check_word("mem_din_o", mem_din_o, e.din);
        check_addr("mem_addr_o", mem_addr_o, e.maddr);
        check_bit("jump_en_o", jump_en_o, e.jen);
        check_addr("jump_base_o", jump_base_o, e.jbase);
        check_addr("jump_ofst_o", jump_ofst_o, e.jofst);
        if (vec_bad)
            n_fail++;
        else
            n_pass++;
    endtask

    // sample inputs mid-cycle, check them one edge later
    always @(negedge clk) begin : compare_proc
        in_set_t s;
        if (exp_q.size() != 0)
            compare_out(exp_q.pop_front());
        if (rst_n_i && vld) begin
            s.inst     = inst_i;
            s.instaddr = instaddr_i;
            s.rs1      = rs1_data_i;
            s.rs2      = rs2_data_i;
            s.op1      = op1_i;
            s.op2      = op2_i;
            s.wen      = regs_wen_i;
            s.rd       = rd_addr_i;
            exp_q.push_back(ex_ref(s));
        end
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("timeout reached after %0d cycles", cyc_cnt);
            $display("checks: %0d passed, %0d failed", n_pass, n_fail + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        rst_n_i    = 1'b0;
        inst_i     = '0; // opcode 0 is idle
        instaddr_i = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        op1_i      = '0;
        op2_i      = '0;
        regs_wen_i = 1'b0;
        rd_addr_i  = '0;
        vld        = 1'b0;
        vec_bad    = 1'b0;

        repeat (5) begin
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_idle("after reset");
        $display("%-10s %0d checks, %0d errors", "reset", n_pass + n_fail, n_fail);

        run_test("int_ops", 0, N_INT);
        run_test("shifts", 1, N_SHIFT);
        run_test("control", 2, N_CTRL);
        run_test("mem", 3, N_MEM);
        run_test("stream", 4, N_STREAM);

        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/rv_isa_pkg.sv
source/ex_bus_pkg.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_lsu_req.sv
source/ex_stage_reg.sv
source/ex_top.sv
verif/tb_ex_top.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - source/rv_isa_pkg.sv
  - source/ex_bus_pkg.sv
  - source/ex_alu.sv
  - source/ex_branch_unit.sv
  - source/ex_lsu_req.sv
  - source/ex_stage_reg.sv
  - source/ex_top.sv
  - target: simulation
    files:
      - verif/tb_ex_top.sv
